//--- hw/mdio_pkg.sv
/*
  clause-22 register numbers, MDIO frame constants and the PHY init table
*/
`default_nettype none

package mdio_pkg;

  typedef logic [4:0]  reg_addr_t;
  typedef logic [15:0] reg_data_t;

  // standard clause-22 registers
  localparam reg_addr_t REG_BMCR   = 5'd0;
  localparam reg_addr_t REG_BMSR   = 5'd1;
  localparam reg_addr_t REG_PHYID1 = 5'd2;
  localparam reg_addr_t REG_ANAR   = 5'd4;
  // vendor specific control register
  localparam reg_addr_t REG_VENDOR = 5'd16;

  localparam int BMSR_LINK_BIT = 2;

  // ---------------------------------------------------------------------
  // frame layout: preamble, start, opcode, phy, reg, turnaround, data
  // ---------------------------------------------------------------------
  localparam int          FRAME_BITS     = 64;
  localparam logic [31:0] FRAME_PREAMBLE = 32'hFFFF_FFFF;
  localparam logic [1:0]  FRAME_START    = 2'b01;
  localparam logic [1:0]  OP_READ        = 2'b10;
  localparam logic [1:0]  OP_WRITE       = 2'b01;
  localparam logic [1:0]  TA_WRITE       = 2'b10;

  typedef struct packed {
    reg_addr_t addr;
    reg_data_t data;
  } init_entry_t;

  localparam int INIT_COUNT = 3;

  // autoneg enable + restart, advertise 10/100 full/half, vendor led mode
  localparam init_entry_t INIT_TABLE [0:INIT_COUNT-1] = '{
    '{addr: REG_BMCR,   data: 16'h1200},
    '{addr: REG_ANAR,   data: 16'h01E1},
    '{addr: REG_VENDOR, data: 16'h0162}
  };

endpackage

`default_nettype wire

//--- hw/mdio_master.sv
/*
  MDIO frame shifter: builds clause-22 read/write frames, drives the
  tri-state data pin and captures read data
*/
`timescale 1ns/1ns
`default_nettype none

module mdio_master #(
  parameter logic [4:0] PHY_ADDR = 5'd4
) (
  input  wire                clock,
  input  wire                rst,
  input  mdio_pkg::reg_addr_t addr,
  input  mdio_pkg::reg_data_t wr_data,
  input  wire                rd_request,
  input  wire                wr_request,
  output logic               ready,
  output mdio_pkg::reg_data_t rd_data,
  output logic               mdc,
  inout  wire                mdio_pin
);

  import mdio_pkg::*;

  localparam int CNT_W    = $clog2(FRAME_BITS);
  // turnaround starts here, data phase is bits 15..0
  localparam int TA_MSB   = 17;
  localparam int DATA_MSB = 15;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_READING,
    ST_WRITING
  } state_t;

  state_t                 state;
  logic [CNT_W-1:0]       bit_no;
  logic [FRAME_BITS-1:0]  frame;
  logic [FRAME_BITS-1:0]  rd_frame;
  logic [FRAME_BITS-1:0]  wr_frame;
  logic                   pin_oe;

  // read frame keeps the data field at ones, the pin is released there
  assign rd_frame = {FRAME_PREAMBLE, FRAME_START, OP_READ, PHY_ADDR, addr,
                     2'b11, 16'hFFFF};
  assign wr_frame = {FRAME_PREAMBLE, FRAME_START, OP_WRITE, PHY_ADDR, addr,
                     TA_WRITE, wr_data};

  // ---------------------------------------------------------------------
  // bit sequencer, runs on the falling edge so mdio is stable at rising mdc
  // ---------------------------------------------------------------------
  always_ff @(negedge clock)
  begin
    if (rst)
    begin
      state  <= ST_IDLE;
      bit_no <= CNT_W'(FRAME_BITS - 1);
    end
    else
    begin
      case (state)
        ST_IDLE:
        begin
          bit_no <= CNT_W'(FRAME_BITS - 1);
          if (rd_request)
            state <= ST_READING;
          else if (wr_request)
            state <= ST_WRITING;
        end
        ST_READING, ST_WRITING:
        begin
          // last bit shifted, back to idle on this edge
          if (bit_no == '0)
            state <= ST_IDLE;
          bit_no <= bit_no - 1'b1;
        end
        default:
          state <= ST_IDLE;
      endcase
    end
  end

  // frame copy so the requester may change addr/wr_data afterwards
  always_ff @(negedge clock)
  begin
    if (state == ST_IDLE && (rd_request || wr_request))
      frame <= rd_request ? rd_frame : wr_frame;
  end

  // read data sampled at rising mdc during the data phase
  always_ff @(posedge clock)
  begin
    if (state == ST_READING && bit_no <= CNT_W'(DATA_MSB))
      rd_data <= {rd_data[DATA_MSB-1:0], mdio_pin};
  end

  // ---------------------------------------------------------------------
  // pins
  // ---------------------------------------------------------------------
  // released in idle and from turnaround onward on reads
  assign pin_oe   = (state == ST_WRITING) ||
                    (state == ST_READING && bit_no > CNT_W'(TA_MSB));
  assign mdio_pin = pin_oe ? frame[bit_no] : 1'bz;

  // mdc is the system clock itself
  assign mdc   = clock;
  assign ready = (state == ST_IDLE);

  // requester must wait for ready before starting another frame
  a_no_req_when_busy: assert property (
    @(negedge clock) disable iff (rst)
    (rd_request || wr_request) |-> ready
  );

endmodule

`default_nettype wire

//--- hw/mdio_arbiter.sv
/*
  shares one MDIO master between init sequencer, host port and link monitor
*/
`timescale 1ns/1ns
`default_nettype none

module mdio_arbiter (
  input  wire                 clock,
  input  wire                 rst,
  input  wire                 init_done,
  // init sequencer
  input  wire                 init_wr,
  input  mdio_pkg::reg_addr_t init_addr,
  input  mdio_pkg::reg_data_t init_data,
  output logic                init_done_pulse,
  // host port
  input  wire                 host_rd,
  input  wire                 host_wr,
  input  mdio_pkg::reg_addr_t host_addr,
  input  mdio_pkg::reg_data_t host_wr_data,
  output logic                host_done,
  output mdio_pkg::reg_data_t host_rd_data,
  output logic                host_ready,
  // link monitor
  input  wire                 mon_rd,
  input  mdio_pkg::reg_addr_t mon_addr,
  output logic                mon_done,
  output mdio_pkg::reg_data_t mon_rd_data,
  // master side
  input  wire                 ready,
  input  mdio_pkg::reg_data_t rd_data,
  output mdio_pkg::reg_addr_t addr,
  output mdio_pkg::reg_data_t wr_data,
  output logic                rd_request,
  output logic                wr_request
);

  import mdio_pkg::*;

  typedef enum logic [1:0] {
    OWN_NONE,
    OWN_INIT,
    OWN_HOST,
    OWN_MON
  } owner_t;

  owner_t    owner;
  logic      init_pend;
  logic      host_pend;
  logic      mon_pend;
  logic      host_is_wr;
  reg_addr_t init_addr_q;
  reg_data_t init_data_q;
  reg_addr_t host_addr_q;
  reg_data_t host_data_q;
  reg_addr_t mon_addr_q;
  logic      ready_q;
  logic      idle;
  logic      frame_end;
  logic      grant_init;
  logic      grant_host;
  logic      grant_mon;

  // master free and no frame owned
  assign idle       = ready && (owner == OWN_NONE);
  // ready rising edge closes the owner's frame
  assign frame_end  = ready && !ready_q && (owner != OWN_NONE);
  // fixed priority init > host > monitor
  assign grant_init = idle && init_pend;
  assign grant_host = idle && !init_pend && host_pend;
  assign grant_mon  = idle && !init_pend && !host_pend && mon_pend;

  assign host_ready = init_done && !host_pend && (owner != OWN_HOST);

  // ---------------------------------------------------------------------
  // pending latches, ownership and done pulses
  // ---------------------------------------------------------------------
  always_ff @(posedge clock)
  begin
    if (rst)
    begin
      owner           <= OWN_NONE;
      init_pend       <= 1'b0;
      host_pend       <= 1'b0;
      mon_pend        <= 1'b0;
      ready_q         <= 1'b1;
      rd_request      <= 1'b0;
      wr_request      <= 1'b0;
      init_done_pulse <= 1'b0;
      host_done       <= 1'b0;
      mon_done        <= 1'b0;
    end
    else
    begin
      ready_q         <= ready;
      rd_request      <= 1'b0;
      wr_request      <= 1'b0;
      init_done_pulse <= frame_end && (owner == OWN_INIT);
      host_done       <= frame_end && (owner == OWN_HOST);
      mon_done        <= frame_end && (owner == OWN_MON);

      if (frame_end)
        owner <= OWN_NONE;

      if (grant_init)
      begin
        owner      <= OWN_INIT;
        init_pend  <= 1'b0;
        wr_request <= 1'b1;
      end
      else if (grant_host)
      begin
        owner      <= OWN_HOST;
        host_pend  <= 1'b0;
        rd_request <= !host_is_wr;
        wr_request <= host_is_wr;
      end
      else if (grant_mon)
      begin
        owner      <= OWN_MON;
        mon_pend   <= 1'b0;
        rd_request <= 1'b1;
      end

      // one request per client at a time, so no clash with the grant
      if (init_wr)
        init_pend <= 1'b1;
      if (host_rd || host_wr)
        host_pend <= 1'b1;
      if (mon_rd)
        mon_pend <= 1'b1;
    end
  end

  // request copies and routed data
  always_ff @(posedge clock)
  begin
    if (init_wr)
    begin
      init_addr_q <= init_addr;
      init_data_q <= init_data;
    end
    if (host_rd || host_wr)
    begin
      host_addr_q <= host_addr;
      host_data_q <= host_wr_data;
      host_is_wr  <= host_wr;
    end
    if (mon_rd)
      mon_addr_q <= mon_addr;

    if (grant_init)
    begin
      addr    <= init_addr_q;
      wr_data <= init_data_q;
    end
    else if (grant_host)
    begin
      addr    <= host_addr_q;
      wr_data <= host_data_q;
    end
    else if (grant_mon)
      addr <= mon_addr_q;

    if (frame_end && owner == OWN_HOST)
      host_rd_data <= rd_data;
    if (frame_end && owner == OWN_MON)
      mon_rd_data <= rd_data;
  end

  // a second request may only follow once the master has gone busy
  a_one_req_per_idle: assert property (
    @(posedge clock) disable iff (rst)
    (rd_request || wr_request) |=> !(rd_request || wr_request) until !ready
  );

endmodule

`default_nettype wire

//--- hw/phy_init_seq.sv
/*
  writes the init table to the PHY after reset, then holds init_done
*/
`timescale 1ns/1ns
`default_nettype none

module phy_init_seq (
  input  wire                 clock,
  input  wire                 rst,
  input  wire                 done_pulse,
  output logic                init_wr,
  output mdio_pkg::reg_addr_t init_addr,
  output mdio_pkg::reg_data_t init_data,
  output logic                init_done
);

  import mdio_pkg::*;

  localparam int IDX_W = $clog2(INIT_COUNT + 1);

  logic [IDX_W-1:0] idx;
  logic             waiting;
  logic             issue;

  // next write goes out when nothing is outstanding
  assign issue = !waiting && !init_done;

  // ---------------------------------------------------------------------
  // sequencing
  // ---------------------------------------------------------------------
  always_ff @(posedge clock)
  begin
    if (rst)
    begin
      idx       <= '0;
      waiting   <= 1'b0;
      init_wr   <= 1'b0;
      init_done <= 1'b0;
    end
    else
    begin
      init_wr <= 1'b0;
      if (waiting)
      begin
        if (done_pulse)
        begin
          waiting <= 1'b0;
          idx     <= idx + 1'b1;
          // last entry written
          if (idx == IDX_W'(INIT_COUNT - 1))
            init_done <= 1'b1;
        end
      end
      else if (issue)
      begin
        init_wr <= 1'b1;
        waiting <= 1'b1;
      end
    end
  end

  // entry fields presented together with init_wr
  always_ff @(posedge clock)
  begin
    if (issue)
    begin
      init_addr <= INIT_TABLE[idx].addr;
      init_data <= INIT_TABLE[idx].data;
    end
  end

  // a done only comes back for the write in flight
  a_done_when_waiting: assert property (
    @(posedge clock) disable iff (rst)
    done_pulse |-> waiting
  );

endmodule

`default_nettype wire

//--- hw/link_monitor.sv
/*
  polls the basic status register and tracks the PHY link bit
*/
`timescale 1ns/1ns
`default_nettype none

module link_monitor #(
  parameter int POLL_INTERVAL = 200
) (
  input  wire                 clock,
  input  wire                 rst,
  input  wire                 enable,
  input  wire                 done_pulse,
  input  mdio_pkg::reg_data_t rd_data,
  output logic                mon_rd,
  output mdio_pkg::reg_addr_t mon_addr,
  output logic                link_up,
  output logic                link_change
);

  import mdio_pkg::*;

  localparam int CNT_W = (POLL_INTERVAL > 1) ? $clog2(POLL_INTERVAL) : 1;

  logic [CNT_W-1:0] interval_cnt;
  logic             busy;
  logic             link_bit;

  assign link_bit = rd_data[BMSR_LINK_BIT];
  // only ever reads the status register
  assign mon_addr = REG_BMSR;

  // ---------------------------------------------------------------------
  // poll timer and link tracking
  // ---------------------------------------------------------------------
  always_ff @(posedge clock)
  begin
    if (rst)
    begin
      interval_cnt <= '0;
      busy         <= 1'b0;
      mon_rd       <= 1'b0;
      link_up      <= 1'b0;
      link_change  <= 1'b0;
    end
    else
    begin
      mon_rd      <= 1'b0;
      link_change <= 1'b0;
      if (busy)
      begin
        // counter stays at zero until the read completes
        if (done_pulse)
        begin
          busy        <= 1'b0;
          link_up     <= link_bit;
          link_change <= (link_bit != link_up);
        end
      end
      else if (enable)
      begin
        if (interval_cnt == CNT_W'(POLL_INTERVAL - 1))
        begin
          interval_cnt <= '0;
          mon_rd       <= 1'b1;
          busy         <= 1'b1;
        end
        else
          interval_cnt <= interval_cnt + 1'b1;
      end
    end
  end

  // a done only comes back for the status read in flight
  a_done_when_busy: assert property (
    @(posedge clock) disable iff (rst)
    done_pulse |-> busy
  );

endmodule

`default_nettype wire

//--- hw/phy_mgmt_top.sv
/*
  PHY management top: MDIO master, arbiter, init sequencer, link monitor
*/
`timescale 1ns/1ns
`default_nettype none

module phy_mgmt_top #(
  parameter logic [4:0] PHY_ADDR      = 5'd4,
  parameter int         POLL_INTERVAL = 200
) (
  input  wire                 clock,
  input  wire                 rst,
  input  wire                 host_rd,
  input  wire                 host_wr,
  input  mdio_pkg::reg_addr_t host_addr,
  input  mdio_pkg::reg_data_t host_wr_data,
  output mdio_pkg::reg_data_t host_rd_data,
  output logic                host_done,
  output logic                host_ready,
  output logic                init_done,
  output logic                link_up,
  output logic                link_change,
  output logic                mdc,
  inout  wire                 mdio_pin
);

  import mdio_pkg::*;

  // master side
  reg_addr_t m_addr;
  reg_data_t m_wr_data;
  reg_data_t m_rd_data;
  logic      m_rd_request;
  logic      m_wr_request;
  logic      m_ready;
  // clients
  logic      init_wr;
  reg_addr_t init_addr;
  reg_data_t init_data;
  logic      init_done_pulse;
  logic      mon_rd;
  reg_addr_t mon_addr;
  logic      mon_done;
  reg_data_t mon_rd_data;

  mdio_master #(
    .PHY_ADDR (PHY_ADDR)
  ) u_master (
    .clock      (clock),
    .rst        (rst),
    .addr       (m_addr),
    .wr_data    (m_wr_data),
    .rd_request (m_rd_request),
    .wr_request (m_wr_request),
    .ready      (m_ready),
    .rd_data    (m_rd_data),
    .mdc        (mdc),
    .mdio_pin   (mdio_pin)
  );

  mdio_arbiter u_arbiter (
    .clock           (clock),
    .rst             (rst),
    .init_done       (init_done),
    .init_wr         (init_wr),
    .init_addr       (init_addr),
    .init_data       (init_data),
    .init_done_pulse (init_done_pulse),
    .host_rd         (host_rd),
    .host_wr         (host_wr),
    .host_addr       (host_addr),
    .host_wr_data    (host_wr_data),
    .host_done       (host_done),
    .host_rd_data    (host_rd_data),
    .host_ready      (host_ready),
    .mon_rd          (mon_rd),
    .mon_addr        (mon_addr),
    .mon_done        (mon_done),
    .mon_rd_data     (mon_rd_data),
    .ready           (m_ready),
    .rd_data         (m_rd_data),
    .addr            (m_addr),
    .wr_data         (m_wr_data),
    .rd_request      (m_rd_request),
    .wr_request      (m_wr_request)
  );

  phy_init_seq u_init_seq (
    .clock      (clock),
    .rst        (rst),
    .done_pulse (init_done_pulse),
    .init_wr    (init_wr),
    .init_addr  (init_addr),
    .init_data  (init_data),
    .init_done  (init_done)
  );

  // polling starts once the init table is written
  link_monitor #(
    .POLL_INTERVAL (POLL_INTERVAL)
  ) u_link_monitor (
    .clock       (clock),
    .rst         (rst),
    .enable      (init_done),
    .done_pulse  (mon_done),
    .rd_data     (mon_rd_data),
    .mon_rd      (mon_rd),
    .mon_addr    (mon_addr),
    .link_up     (link_up),
    .link_change (link_change)
  );

endmodule

`default_nettype wire

//--- test/phy_model.sv
/*
  behavioral clause-22 MDIO slave: 32-word register file, preset ID and
  status words, link bit forced from outside, peek port for the testbench
*/
`timescale 1ns/1ns
`default_nettype none

module phy_model #(
  parameter logic [4:0]  PHY_ADDR = 5'd4,
  parameter logic [15:0] ID1      = 16'h0243
) (
  input  wire         rst,
  input  wire         mdc,
  inout  wire         mdio_pin,
  input  wire         link_force,
  input  wire  [4:0]  peek_addr,
  output logic [15:0] peek_data
);

  import mdio_pkg::*;

  typedef enum logic [1:0] {
    S_PRE,
    S_START,
    S_HDR,
    S_BODY
  } state_t;

  state_t      state;
  logic [5:0]  ones;
  logic [3:0]  hdr_cnt;
  logic [10:0] hdr;
  logic [4:0]  bit_idx;
  logic [15:0] shift;
  logic        is_read;
  logic        match;
  reg_addr_t   reg_q;
  reg_data_t   rd_word;
  reg_data_t   regs [0:31];
  logic        drive_oe;
  logic        drive_val;

  // status word carries the forced link bit
  always_comb
  begin
    rd_word = regs[reg_q];
    if (reg_q == REG_BMSR)
      rd_word[BMSR_LINK_BIT] = link_force;
  end

  assign peek_data = regs[peek_addr];
  assign mdio_pin  = drive_oe ? drive_val : 1'bz;

  // ---------------------------------------------------------------------
  // receive side, sampled at rising mdc
  // ---------------------------------------------------------------------
  always_ff @(posedge mdc)
  begin
    if (rst)
    begin
      state   <= S_PRE;
      ones    <= '0;
      hdr_cnt <= '0;
      // fill pattern follows the register number
      for (int i = 0; i < 32; i++)
        regs[i] <= 16'h5A00 + 16'(i);
      regs[1] <= 16'h7849;
      regs[2] <= ID1;
    end
    else
    begin
      case (state)
        S_PRE:
        begin
          // at least 32 ones, then the first start bit
          if (mdio_pin)
          begin
            if (ones != 6'd32)
              ones <= ones + 1'b1;
          end
          else if (ones == 6'd32)
            state <= S_START;
          else
            ones <= '0;
        end
        S_START:
        begin
          hdr_cnt <= '0;
          if (mdio_pin)
            state <= S_HDR;
          else
          begin
            state <= S_PRE;
            ones  <= '0;
          end
        end
        S_HDR:
        begin
          // opcode, phy address, register number
          hdr     <= {hdr[9:0], mdio_pin};
          hdr_cnt <= hdr_cnt + 1'b1;
          if (hdr_cnt == 4'd11)
          begin
            is_read <= (hdr[10:9] == OP_READ);
            match   <= (hdr[8:4] == PHY_ADDR);
            reg_q   <= {hdr[3:0], mdio_pin};
            bit_idx <= 5'd17;
            state   <= S_BODY;
          end
        end
        default:
        begin
          // turnaround and data, bit_idx is the bit just sampled
          if (!is_read && bit_idx <= 5'd15)
            shift <= {shift[14:0], mdio_pin};
          if (bit_idx == 5'd0)
          begin
            if (!is_read && match)
              regs[reg_q] <= {shift[14:0], mdio_pin};
            state <= S_PRE;
            ones  <= '0;
          end
          bit_idx <= bit_idx - 1'b1;
        end
      endcase
    end
  end

  // drive side changes on falling mdc, zero in the second turnaround bit
  always_ff @(negedge mdc)
  begin
    if (rst)
      drive_oe <= 1'b0;
    else if (state == S_BODY && is_read && match && bit_idx <= 5'd16)
    begin
      drive_oe  <= 1'b1;
      drive_val <= (bit_idx == 5'd16) ? 1'b0 : rd_word[bit_idx[3:0]];
    end
    else
      drive_oe <= 1'b0;
  end

endmodule

`default_nettype wire

//--- test/tb_phy_mgmt.sv
/*
  testbench for the PHY management top: clock, reset, host stimulus,
  two PHY models on one bus, assertions, watchdog and summary
*/
`timescale 1ns/1ns
`default_nettype none

module tb_phy_mgmt;

  import mdio_pkg::*;

  localparam logic [4:0]  PHY_ADDR        = 5'd4;
  localparam int          POLL_INTERVAL   = 200;
  localparam logic [15:0] PHY_ID1         = 16'h0243;
  localparam logic [31:0] LCG_SEED        = 32'd99174;
  localparam int          SCRATCH_COUNT   = 8;
  localparam logic [4:0]  SCRATCH_BASE    = 5'd17;
  // two poll intervals plus two frames
  localparam int          LINK_LIMIT      = 2 * POLL_INTERVAL + 2 * FRAME_BITS;
  localparam int          WATCHDOG_CYCLES =
    (INIT_COUNT + 20 + 6) * (FRAME_BITS + POLL_INTERVAL);

  logic      clock;
  logic      rst;
  logic      host_rd;
  logic      host_wr;
  reg_addr_t host_addr;
  reg_data_t host_wr_data;
  reg_data_t host_rd_data;
  logic      host_done;
  logic      host_ready;
  logic      init_done;
  logic      link_up;
  logic      link_change;
  logic      mdc;
  wire       mdio_pin;
  logic      link_force;
  reg_addr_t peek_addr;
  reg_data_t peek_data;
  reg_addr_t other_peek_addr;
  reg_data_t other_peek_data;
  logic      quiet;
  int        errors;
  int        errors_mark;
  int        tests_run;
  int        tests_ok;

  // ---------------------------------------------------------------------
  // DUT, the addressed PHY and a second PHY one address up
  // ---------------------------------------------------------------------
  phy_mgmt_top #(
    .PHY_ADDR      (PHY_ADDR),
    .POLL_INTERVAL (POLL_INTERVAL)
  ) uut (
    .clock        (clock),
    .rst          (rst),
    .host_rd      (host_rd),
    .host_wr      (host_wr),
    .host_addr    (host_addr),
    .host_wr_data (host_wr_data),
    .host_rd_data (host_rd_data),
    .host_done    (host_done),
    .host_ready   (host_ready),
    .init_done    (init_done),
    .link_up      (link_up),
    .link_change  (link_change),
    .mdc          (mdc),
    .mdio_pin     (mdio_pin)
  );

  phy_model #(
    .PHY_ADDR (PHY_ADDR),
    .ID1      (PHY_ID1)
  ) phy (
    .rst        (rst),
    .mdc        (mdc),
    .mdio_pin   (mdio_pin),
    .link_force (link_force),
    .peek_addr  (peek_addr),
    .peek_data  (peek_data)
  );

  // must ignore every frame, never drives the pin
  phy_model #(
    .PHY_ADDR (PHY_ADDR + 5'd1),
    .ID1      (PHY_ID1)
  ) other_phy (
    .rst        (rst),
    .mdc        (mdc),
    .mdio_pin   (mdio_pin),
    .link_force (1'b0),
    .peek_addr  (other_peek_addr),
    .peek_data  (other_peek_data)
  );

  pullup (mdio_pin);

  initial
  begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  // ---------------------------------------------------------------------
  // assertions
  // ---------------------------------------------------------------------
  // outputs idle and bus released around reset
  a_quiet: assert property (@(posedge clock)
    quiet |-> (!host_ready && !init_done && !link_up && !link_change && mdio_pin === 1'b1))
  else
  begin
    $display("[FAIL] %0t: outputs or mdio pin not idle around reset", $time);
    errors++;
  end

  a_host_gate: assert property (@(posedge clock) disable iff (rst)
    (host_rd || host_wr) |-> host_ready)
  else
  begin
    $display("[FAIL] %0t: host request issued while host_ready low", $time);
    errors++;
  end

  a_ready_after_init: assert property (@(posedge clock) disable iff (rst)
    !init_done |-> !host_ready)
  else
  begin
    $display("[FAIL] %0t: host_ready high before init_done", $time);
    errors++;
  end

  a_init_sticky: assert property (@(posedge clock) disable iff (rst)
    !$fell(init_done))
  else
  begin
    $display("[FAIL] %0t: init_done fell without reset", $time);
    errors++;
  end

  a_done_pulse: assert property (@(posedge clock) disable iff (rst)
    host_done |=> !host_done)
  else
  begin
    $display("[FAIL] %0t: host_done longer than one cycle", $time);
    errors++;
  end

  // one change pulse exactly when link_up moves
  a_change_matches: assert property (@(posedge clock) disable iff (rst)
    link_change == (link_up != $past(link_up)))
  else
  begin
    $display("[FAIL] %0t: link_change does not match link_up edge", $time);
    errors++;
  end

  // ---------------------------------------------------------------------
  // helpers
  // ---------------------------------------------------------------------
  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
  endfunction

  task automatic apply_reset();
    rst = 1'b1;
    repeat (4) @(negedge clock);
    quiet = 1'b1;
    repeat (12) @(negedge clock);
    rst = 1'b0;
    // the first frame starts a few cycles later
    repeat (2) @(negedge clock);
    quiet = 1'b0;
  endtask

  // called on a falling edge, returns on the falling edge after host_done
  task automatic host_access(input logic is_wr, input reg_addr_t addr,
                             input reg_data_t data, output reg_data_t rdata);
    while (!host_ready)
      @(negedge clock);
    host_rd      = !is_wr;
    host_wr      = is_wr;
    host_addr    = addr;
    host_wr_data = data;
    @(negedge clock);
    host_rd = 1'b0;
    host_wr = 1'b0;
    while (!host_done)
      @(negedge clock);
    rdata = host_rd_data;
  endtask

  task automatic peek_regs(input reg_addr_t addr, output reg_data_t main_word,
                           output reg_data_t other_word);
    peek_addr       = addr;
    other_peek_addr = addr;
    @(negedge clock);
    main_word  = peek_data;
    other_word = other_peek_data;
  endtask

  task automatic check_word(input string what, input reg_data_t got,
                            input reg_data_t expected);
    assert (got === expected)
    else
    begin
      $display("[FAIL] %0t: %s is %h, expected %h", $time, what, got, expected);
      errors++;
    end
  endtask

  // wait for link_up to follow the forced bit, count change pulses
  task automatic wait_link(input logic target);
    int cycles;
    int pulses;
    cycles = 0;
    pulses = 0;
    while (link_up !== target && cycles < LINK_LIMIT)
    begin
      @(negedge clock);
      cycles++;
      if (link_change)
        pulses++;
    end
    assert (link_up === target)
    else
    begin
      $display("link_up did not reach %0b within %0d cycles", target, LINK_LIMIT);
      errors++;
    end
    // one more poll must not pulse again
    repeat (POLL_INTERVAL + FRAME_BITS + 8)
    begin
      @(negedge clock);
      if (link_change)
        pulses++;
    end
    assert (pulses == 1)
    else
    begin
      $display("[FAIL] %0t: %0d link_change pulses, expected 1", $time, pulses);
      errors++;
    end
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (errors == errors_mark)
    begin
      tests_ok++;
      $display("test %0d %s: ok", tests_run, name);
    end
    else
      $display("test %0d %s: %0d errors", tests_run, name, errors - errors_mark);
    errors_mark = errors;
  endtask

  // ---------------------------------------------------------------------
  // watchdog
  // ---------------------------------------------------------------------
  initial
  begin
    repeat (WATCHDOG_CYCLES) @(posedge clock);
    $display("simulation timed out after %0d cycles", WATCHDOG_CYCLES);
    $display("tests failed");
    $finish;
  end

  // ---------------------------------------------------------------------
  // stimulus
  // ---------------------------------------------------------------------
  initial
  begin
    reg_data_t   word;
    reg_data_t   other_word;
    reg_data_t   wr_val;
    reg_data_t   other_before [SCRATCH_COUNT];
    logic [31:0] lcg_state;

    rst             = 1'b1;
    host_rd         = 1'b0;
    host_wr         = 1'b0;
    host_addr       = '0;
    host_wr_data    = '0;
    link_force      = 1'b0;
    peek_addr       = '0;
    other_peek_addr = '0;
    quiet           = 1'b0;
    errors          = 0;
    errors_mark     = 0;
    tests_run       = 0;
    tests_ok        = 0;
    lcg_state       = LCG_SEED;

    apply_reset();
    finish_test("reset state");

    // init table lands in the addressed PHY
    while (!init_done)
      @(negedge clock);
    for (int i = 0; i < INIT_COUNT; i++)
    begin
      peek_regs(INIT_TABLE[i].addr, word, other_word);
      check_word("init register", word, INIT_TABLE[i].data);
    end
    finish_test("init table");

    host_access(1'b0, REG_PHYID1, 16'h0000, word);
    check_word("phy id read", word, PHY_ID1);
    finish_test("phy id read");

    // scratch writes with readback, second PHY keeps its contents
    for (int i = 0; i < SCRATCH_COUNT; i++)
      peek_regs(SCRATCH_BASE + 5'(i), word, other_before[i]);
    for (int i = 0; i < SCRATCH_COUNT; i++)
    begin
      lcg_state = lcg_next(lcg_state);
      wr_val    = lcg_state[23:8];
      host_access(1'b1, SCRATCH_BASE + 5'(i), wr_val, word);
      host_access(1'b0, SCRATCH_BASE + 5'(i), 16'h0000, word);
      check_word("scratch readback", word, wr_val);
    end
    for (int i = 0; i < SCRATCH_COUNT; i++)
    begin
      peek_regs(SCRATCH_BASE + 5'(i), word, other_word);
      check_word("other phy register", other_word, other_before[i]);
    end
    finish_test("scratch write and read");

    link_force = 1'b1;
    wait_link(1'b1);
    link_force = 1'b0;
    wait_link(1'b0);
    finish_test("link tracking");

    $display("summary: %0d tests, %0d ok, %0d check errors", tests_run, tests_ok, errors);
    if (errors == 0)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- sim.f
hw/mdio_pkg.sv
hw/mdio_master.sv
hw/mdio_arbiter.sv
hw/phy_init_seq.sv
hw/link_monitor.sv
hw/phy_mgmt_top.sv
test/phy_model.sv
test/tb_phy_mgmt.sv

//--- run_sim.sh
#!/bin/sh
# build with Verilator, run, then look for the fail message in the log
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_phy_mgmt \
  -f sim.f -o tb_phy_mgmt > build.log 2>&1 &&
./obj_dir/tb_phy_mgmt > sim.log 2>&1 ||
{ cat build.log sim.log 2>/dev/null; echo "build or run error"; exit 1; }
cat sim.log &&
! grep -q "tests failed" sim.log
